//--- rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;        // Data, PC or target
    typedef logic [4:0]  reg_addr_t;    // Register number
    typedef logic [5:0]  funct_t;       // ALU function code
    typedef logic [5:0]  opcode_t;      // Major opcode
    typedef logic [15:0] imm_t;         // Raw immediate field
    typedef logic [25:0] jump_index_t;  // J-type index field
    typedef logic [1:0]  addr_src_t;    // Where the new PC comes from
    typedef logic [1:0]  mem_size_t;    // Memory access size

    localparam int NUM_REGS = 32;

    // Major opcodes handled by exact match
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;

    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;

    localparam reg_addr_t LINK_REG = 5'd31;   // Return address for JAL

    localparam addr_src_t ADDR_SRC_REG    = 2'b00;  // Target is rs data
    localparam addr_src_t ADDR_SRC_JUMP   = 2'b01;  // PC+4 upper bits and index << 2
    localparam addr_src_t ADDR_SRC_BRANCH = 2'b10;  // PC+4 plus offset << 2

    localparam mem_size_t MEM_BYTE = 2'b00;
    localparam mem_size_t MEM_HALF = 2'b01;
    localparam mem_size_t MEM_WORD = 2'b11;

    // Return address skips the delay slot
    localparam word_t LINK_OFFSET = 32'd8;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import mips_pkg::*; (
    input  word_t       i_instr,

    output reg_addr_t   o_rs,
    output reg_addr_t   o_rt,
    output reg_addr_t   o_dest_reg,
    output funct_t      o_funct,            // R-type funct, or low opcode bits for immediates
    output logic [4:0]  o_shamt,
    output word_t       o_imm_ext,
    output jump_index_t o_jump_index,

    output logic        o_reg_write,
    output logic        o_pc_modify,        // Jump or branch
    output logic        o_link,             // Saves the return address
    output addr_src_t   o_addr_src,
    output logic        o_branch_eq,        // 1 for BEQ, 0 for BNE

    output logic        o_mem_op,
    output logic        o_mem_store,        // 0 load, 1 store
    output mem_size_t   o_mem_size,
    output logic        o_mem_unsigned
);

    opcode_t   opcode;
    imm_t      imm;
    reg_addr_t rs_field;
    reg_addr_t rt_field;
    reg_addr_t rd_field;
    word_t     imm_sext;
    word_t     imm_zext;

    assign opcode   = i_instr[31:26];
    assign imm      = i_instr[15:0];
    assign rs_field = i_instr[25:21];
    assign rt_field = i_instr[20:16];
    assign rd_field = i_instr[15:11];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'b0, imm};

    always_comb begin
        // Anything not matched below decodes as a no-op
        o_rs           = '0;
        o_rt           = '0;
        o_dest_reg     = '0;
        o_funct        = '0;
        o_shamt        = '0;
        o_imm_ext      = '0;
        o_jump_index   = '0;
        o_reg_write    = 1'b0;
        o_pc_modify    = 1'b0;
        o_link         = 1'b0;
        o_addr_src     = ADDR_SRC_REG;
        o_branch_eq    = 1'b0;
        o_mem_op       = 1'b0;
        o_mem_store    = 1'b0;
        o_mem_size     = MEM_BYTE;
        o_mem_unsigned = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                o_rs = rs_field;
                case (i_instr[5:0])
                    FN_JR: begin
                        o_pc_modify = 1'b1;         // Target from rs
                    end
                    FN_JALR: begin
                        o_pc_modify = 1'b1;
                        o_link      = 1'b1;
                        o_dest_reg  = rd_field;
                        o_reg_write = 1'b1;
                    end
                    default: begin
                        o_rt        = rt_field;
                        o_dest_reg  = rd_field;
                        o_funct     = i_instr[5:0];
                        o_shamt     = i_instr[10:6];
                        o_reg_write = 1'b1;
                    end
                endcase
            end
            OP_J, OP_JAL: begin
                o_jump_index = i_instr[25:0];
                o_pc_modify  = 1'b1;
                o_addr_src   = ADDR_SRC_JUMP;
                if (opcode == OP_JAL) begin
                    o_link      = 1'b1;
                    o_dest_reg  = LINK_REG;
                    o_reg_write = 1'b1;
                end
            end
            OP_BEQ, OP_BNE: begin
                o_rs        = rs_field;
                o_rt        = rt_field;
                o_imm_ext   = imm_sext;             // Word offset
                o_pc_modify = 1'b1;
                o_addr_src  = ADDR_SRC_BRANCH;
                o_branch_eq = (opcode == OP_BEQ);
            end
            default: begin
                case (opcode[5:3])
                    3'b001: begin                   // Immediate arithmetic
                        o_rs        = rs_field;
                        o_rt        = rt_field;
                        o_dest_reg  = rt_field;
                        o_funct     = {3'b000, opcode[2:0]};
                        o_imm_ext   = opcode[2] ? imm_zext : imm_sext;  // Logic ops zero-extend
                        o_reg_write = 1'b1;
                    end
                    3'b100: begin                   // Loads
                        o_rs           = rs_field;
                        o_rt           = rt_field;
                        o_dest_reg     = rt_field;
                        o_imm_ext      = imm_sext;
                        o_reg_write    = 1'b1;
                        o_mem_op       = 1'b1;
                        o_mem_size     = opcode[1:0];
                        o_mem_unsigned = opcode[2];
                    end
                    3'b101: begin                   // Stores
                        o_rs        = rs_field;
                        o_rt        = rt_field;
                        o_imm_ext   = imm_sext;
                        o_mem_op    = 1'b1;
                        o_mem_store = 1'b1;
                        o_mem_size  = opcode[1:0];
                    end
                    default: begin
                    end
                endcase
            end
        endcase
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

module register_file import mips_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,

    input  reg_addr_t i_rs_addr,
    input  reg_addr_t i_rt_addr,
    output word_t     o_rs_data,
    output word_t     o_rt_data,

    input  logic      i_wb_en,
    input  reg_addr_t i_wb_reg,
    input  word_t     i_wb_data
);

    word_t regs [NUM_REGS];
    logic  wb_valid;

    assign wb_valid = i_wb_en && (i_wb_reg != '0);  // r0 is never written

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    // Same-cycle write is forwarded to the readers
    always_comb begin
        if (i_rs_addr == '0)
            o_rs_data = '0;
        else if (wb_valid && (i_wb_reg == i_rs_addr))
            o_rs_data = i_wb_data;
        else
            o_rs_data = regs[i_rs_addr];

        if (i_rt_addr == '0)
            o_rt_data = '0;
        else if (wb_valid && (i_wb_reg == i_rt_addr))
            o_rt_data = i_wb_data;
        else
            o_rt_data = regs[i_rt_addr];
    end

endmodule

//--- rtl/branch_resolver.sv
`timescale 1ns/100ps

module branch_resolver import mips_pkg::*; (
    input  word_t       i_pc,

    input  logic        i_pc_modify,
    input  addr_src_t   i_addr_src,
    input  logic        i_branch_eq,

    input  word_t       i_rs_data,
    input  word_t       i_rt_data,
    input  word_t       i_imm_ext,
    input  jump_index_t i_jump_index,

    output logic        o_taken,
    output word_t       o_target,
    output word_t       o_link_value
);

    word_t pc_plus4;
    logic  regs_equal;

    assign pc_plus4     = i_pc + 32'd4;
    assign regs_equal   = (i_rs_data == i_rt_data);
    assign o_link_value = i_pc + LINK_OFFSET;

    always_comb begin
        case (i_addr_src)
            ADDR_SRC_REG:    o_target = i_rs_data;                              // JR, JALR
            ADDR_SRC_JUMP:   o_target = {pc_plus4[31:28], i_jump_index, 2'b00};
            ADDR_SRC_BRANCH: o_target = pc_plus4 + {i_imm_ext[29:0], 2'b00};
            default:         o_target = pc_plus4;
        endcase
    end

    // Jumps always go, branches only when the compare matches BEQ/BNE
    always_comb begin
        if (!i_pc_modify)
            o_taken = 1'b0;
        else if (i_addr_src == ADDR_SRC_BRANCH)
            o_taken = (regs_equal == i_branch_eq);
        else
            o_taken = 1'b1;
    end

endmodule

//--- rtl/id_ex_register.sv
`timescale 1ns/100ps

module id_ex_register import mips_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_valid,

    input  funct_t      i_funct,
    input  logic [4:0]  i_shamt,
    input  word_t       i_rs_data,
    input  word_t       i_rt_data,
    input  word_t       i_imm_ext,
    input  reg_addr_t   i_dest_reg,
    input  logic        i_reg_write,
    input  logic        i_link,
    input  word_t       i_link_value,
    input  logic        i_mem_op,
    input  logic        i_mem_store,
    input  mem_size_t   i_mem_size,
    input  logic        i_mem_unsigned,
    input  logic        i_branch_taken,
    input  word_t       i_branch_target,

    output logic        o_valid,
    output funct_t      o_funct,
    output logic [4:0]  o_shamt,
    output word_t       o_rs_data,
    output word_t       o_rt_data,
    output word_t       o_imm_ext,
    output reg_addr_t   o_dest_reg,
    output logic        o_reg_write,
    output logic        o_link,
    output word_t       o_link_value,
    output logic        o_mem_op,
    output logic        o_mem_store,
    output mem_size_t   o_mem_size,
    output logic        o_mem_unsigned,
    output logic        o_branch_taken,
    output word_t       o_branch_target
);

    always_ff @(posedge i_clk) begin
        if (i_reset || !i_valid) begin          // Bubble
            o_valid         <= 1'b0;
            o_funct         <= '0;
            o_shamt         <= '0;
            o_rs_data       <= '0;
            o_rt_data       <= '0;
            o_imm_ext       <= '0;
            o_dest_reg      <= '0;
            o_reg_write     <= 1'b0;
            o_link          <= 1'b0;
            o_link_value    <= '0;
            o_mem_op        <= 1'b0;
            o_mem_store     <= 1'b0;
            o_mem_size      <= MEM_BYTE;
            o_mem_unsigned  <= 1'b0;
            o_branch_taken  <= 1'b0;
            o_branch_target <= '0;
        end else begin
            o_valid         <= 1'b1;
            o_funct         <= i_funct;
            o_shamt         <= i_shamt;
            o_rs_data       <= i_rs_data;
            o_rt_data       <= i_rt_data;
            o_imm_ext       <= i_imm_ext;
            o_dest_reg      <= i_dest_reg;
            o_reg_write     <= i_reg_write;
            o_link          <= i_link;
            o_link_value    <= i_link_value;
            o_mem_op        <= i_mem_op;
            o_mem_store     <= i_mem_store;
            o_mem_size      <= i_mem_size;
            o_mem_unsigned  <= i_mem_unsigned;
            o_branch_taken  <= i_branch_taken;
            o_branch_target <= i_branch_target;
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import mips_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_valid,
    input  word_t       i_instr,
    input  word_t       i_pc,

    input  logic        i_wb_en,            // Write-back port
    input  reg_addr_t   i_wb_reg,
    input  word_t       i_wb_data,

    output logic        o_valid,
    output funct_t      o_funct,
    output logic [4:0]  o_shamt,
    output word_t       o_rs_data,
    output word_t       o_rt_data,
    output word_t       o_imm_ext,
    output reg_addr_t   o_dest_reg,
    output logic        o_reg_write,
    output logic        o_link,
    output word_t       o_link_value,
    output logic        o_mem_op,
    output logic        o_mem_store,
    output mem_size_t   o_mem_size,
    output logic        o_mem_unsigned,
    output logic        o_branch_taken,
    output word_t       o_branch_target
);

    reg_addr_t   rs, rt, dest_reg;
    funct_t      funct;
    logic [4:0]  shamt;
    word_t       imm_ext;
    jump_index_t jump_index;
    logic        reg_write, pc_modify, link, branch_eq;
    addr_src_t   addr_src;
    logic        mem_op, mem_store, mem_unsigned;
    mem_size_t   mem_size;
    word_t       rs_data, rt_data;
    logic        taken;
    word_t       target, link_value;

    instr_decoder decoder_i (
        .i_instr(i_instr),
        .o_rs(rs), .o_rt(rt), .o_dest_reg(dest_reg),
        .o_funct(funct), .o_shamt(shamt), .o_imm_ext(imm_ext), .o_jump_index(jump_index),
        .o_reg_write(reg_write), .o_pc_modify(pc_modify), .o_link(link),
        .o_addr_src(addr_src), .o_branch_eq(branch_eq),
        .o_mem_op(mem_op), .o_mem_store(mem_store), .o_mem_size(mem_size),
        .o_mem_unsigned(mem_unsigned)
    );

    register_file regfile_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rs_addr(rs), .i_rt_addr(rt), .o_rs_data(rs_data), .o_rt_data(rt_data),
        .i_wb_en(i_wb_en), .i_wb_reg(i_wb_reg), .i_wb_data(i_wb_data)
    );

    branch_resolver branch_i (
        .i_pc(i_pc), .i_pc_modify(pc_modify), .i_addr_src(addr_src), .i_branch_eq(branch_eq),
        .i_rs_data(rs_data), .i_rt_data(rt_data), .i_imm_ext(imm_ext),
        .i_jump_index(jump_index),
        .o_taken(taken), .o_target(target), .o_link_value(link_value)
    );

    id_ex_register id_ex_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_funct(funct), .i_shamt(shamt), .i_rs_data(rs_data), .i_rt_data(rt_data),
        .i_imm_ext(imm_ext), .i_dest_reg(dest_reg), .i_reg_write(reg_write),
        .i_link(link), .i_link_value(link_value),
        .i_mem_op(mem_op), .i_mem_store(mem_store), .i_mem_size(mem_size),
        .i_mem_unsigned(mem_unsigned),
        .i_branch_taken(taken), .i_branch_target(target),
        .o_valid(o_valid), .o_funct(o_funct), .o_shamt(o_shamt),
        .o_rs_data(o_rs_data), .o_rt_data(o_rt_data), .o_imm_ext(o_imm_ext),
        .o_dest_reg(o_dest_reg), .o_reg_write(o_reg_write),
        .o_link(o_link), .o_link_value(o_link_value),
        .o_mem_op(o_mem_op), .o_mem_store(o_mem_store), .o_mem_size(o_mem_size),
        .o_mem_unsigned(o_mem_unsigned),
        .o_branch_taken(o_branch_taken), .o_branch_target(o_branch_target)
    );

endmodule

//--- bench/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage import mips_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;  // Stimulus is about 370 cycles

    // Bits of the field mask in an expected entry
    localparam int M_FUNCT  = 0;
    localparam int M_SHAMT  = 1;
    localparam int M_RS     = 2;
    localparam int M_RT     = 3;
    localparam int M_IMM    = 4;
    localparam int M_DEST   = 5;
    localparam int M_LINKV  = 6;
    localparam int M_SIZE   = 7;
    localparam int M_UNS    = 8;
    localparam int M_TARGET = 9;

    typedef struct packed {
        logic [9:0]  mask;                 // Fields that the rules define for this word
        logic        valid;
        logic        reg_write;
        logic        link;
        logic        mem_op;
        logic        mem_store;
        logic        taken;
        funct_t      funct;
        logic [4:0]  shamt;
        word_t       rs_data;
        word_t       rt_data;
        word_t       imm_ext;
        reg_addr_t   dest_reg;
        word_t       link_value;
        mem_size_t   mem_size;
        logic        mem_unsigned;
        word_t       target;
    } exp_t;

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        i_valid;
    word_t       i_instr;
    word_t       i_pc;
    logic        i_wb_en;
    reg_addr_t   i_wb_reg;
    word_t       i_wb_data;

    logic        o_valid;
    funct_t      o_funct;
    logic [4:0]  o_shamt;
    word_t       o_rs_data;
    word_t       o_rt_data;
    word_t       o_imm_ext;
    reg_addr_t   o_dest_reg;
    logic        o_reg_write;
    logic        o_link;
    word_t       o_link_value;
    logic        o_mem_op;
    logic        o_mem_store;
    mem_size_t   o_mem_size;
    logic        o_mem_unsigned;
    logic        o_branch_taken;
    word_t       o_branch_target;

    word_t mirror [32];                    // Register file model
    exp_t  exp_q [$];
    word_t rng_state = 32'hbc51;
    int    errors = 0;
    int    checks = 0;
    int    test_start_errors = 0;
    int    cycle_count = 0;

    decode_stage dut_i (.*);

    always #5 i_clk = ~i_clk;

    function automatic word_t xorshift(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t rand_pc();
        word_t r;
        r = next_rand();
        return {r[31:2], 2'b00};
    endfunction

    function automatic word_t rtype_word(input reg_addr_t rs, input reg_addr_t rt,
                                         input reg_addr_t rd, input logic [4:0] shamt,
                                         input funct_t fn);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_addr_t rs,
                                         input reg_addr_t rt, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input jump_index_t idx);
        return {op, idx};
    endfunction

    // Value seen by a reader, with a same-cycle write-back forwarded
    function automatic word_t read_reg(input reg_addr_t addr, input logic wb_en,
                                       input reg_addr_t wb_reg, input word_t wb_data);
        if (addr == 5'd0)
            return '0;
        if (wb_en && wb_reg == addr)
            return wb_data;
        return mirror[addr];
    endfunction

    function automatic exp_t predict(input word_t instr, input word_t pc,
                                     input word_t rs_val, input word_t rt_val);
        exp_t    e;
        opcode_t op;
        funct_t  fn;
        word_t   sext;
        word_t   pc4;
        e    = '0;
        op   = instr[31:26];
        fn   = instr[5:0];
        sext = {{16{instr[15]}}, instr[15:0]};
        pc4  = pc + 32'd4;
        e.valid = 1'b1;
        if (op == OP_RTYPE && (fn == FN_JR || fn == FN_JALR)) begin
            e.taken  = 1'b1;
            e.target = rs_val;             // Register jump
            e.rs_data = rs_val;
            e.mask[M_TARGET] = 1'b1;
            e.mask[M_RS]     = 1'b1;
            if (fn == FN_JALR) begin
                e.reg_write  = 1'b1;
                e.link       = 1'b1;
                e.dest_reg   = instr[15:11];
                e.link_value = pc + LINK_OFFSET;
                e.mask[M_DEST]  = 1'b1;
                e.mask[M_LINKV] = 1'b1;
            end
        end else if (op == OP_RTYPE) begin
            e.reg_write = 1'b1;
            e.funct     = fn;
            e.shamt     = instr[10:6];
            e.rs_data   = rs_val;
            e.rt_data   = rt_val;
            e.dest_reg  = instr[15:11];
            e.mask[M_FUNCT] = 1'b1;
            e.mask[M_SHAMT] = 1'b1;
            e.mask[M_RS]    = 1'b1;
            e.mask[M_RT]    = 1'b1;
            e.mask[M_DEST]  = 1'b1;
        end else if (op == OP_J || op == OP_JAL) begin
            e.taken  = 1'b1;
            e.target = {pc4[31:28], instr[25:0], 2'b00};
            e.mask[M_TARGET] = 1'b1;
            if (op == OP_JAL) begin
                e.reg_write  = 1'b1;
                e.link       = 1'b1;
                e.dest_reg   = LINK_REG;
                e.link_value = pc + LINK_OFFSET;
                e.mask[M_DEST]  = 1'b1;
                e.mask[M_LINKV] = 1'b1;
            end
        end else if (op == OP_BEQ || op == OP_BNE) begin
            e.taken   = (op == OP_BEQ) ? (rs_val == rt_val) : (rs_val != rt_val);
            e.target  = pc4 + (sext << 2);
            e.imm_ext = sext;
            e.rs_data = rs_val;
            e.rt_data = rt_val;
            e.mask[M_TARGET] = 1'b1;
            e.mask[M_IMM]    = 1'b1;
            e.mask[M_RS]     = 1'b1;
            e.mask[M_RT]     = 1'b1;
        end else if (op[5:3] == 3'b001) begin
            e.reg_write = 1'b1;
            e.funct     = {3'b000, op[2:0]};
            e.imm_ext   = op[2] ? {16'h0000, instr[15:0]} : sext;
            e.rs_data   = rs_val;
            e.dest_reg  = instr[20:16];
            e.mask[M_FUNCT] = 1'b1;
            e.mask[M_IMM]   = 1'b1;
            e.mask[M_RS]    = 1'b1;
            e.mask[M_DEST]  = 1'b1;
        end else if (op[5:4] == 2'b10) begin
            e.mem_op    = 1'b1;
            e.mem_store = op[3];           // 101xxx is a store
            e.mem_size  = op[1:0];
            e.imm_ext   = sext;
            e.rs_data   = rs_val;
            e.mask[M_SIZE] = 1'b1;
            e.mask[M_IMM]  = 1'b1;
            e.mask[M_RS]   = 1'b1;
            if (op[3]) begin
                e.rt_data = rt_val;
                e.mask[M_RT] = 1'b1;
            end else begin
                e.reg_write    = 1'b1;
                e.dest_reg     = instr[20:16];
                e.mem_unsigned = op[2];
                e.mask[M_DEST] = 1'b1;
                e.mask[M_UNS]  = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        check_val("o_valid", 32'(o_valid), 32'(e.valid));
        check_val("o_reg_write", 32'(o_reg_write), 32'(e.reg_write));
        check_val("o_link", 32'(o_link), 32'(e.link));
        check_val("o_mem_op", 32'(o_mem_op), 32'(e.mem_op));
        check_val("o_mem_store", 32'(o_mem_store), 32'(e.mem_store));
        check_val("o_branch_taken", 32'(o_branch_taken), 32'(e.taken));
        if (e.mask[M_FUNCT])
            check_val("o_funct", 32'(o_funct), 32'(e.funct));
        if (e.mask[M_SHAMT])
            check_val("o_shamt", 32'(o_shamt), 32'(e.shamt));
        if (e.mask[M_RS])
            check_val("o_rs_data", o_rs_data, e.rs_data);
        if (e.mask[M_RT])
            check_val("o_rt_data", o_rt_data, e.rt_data);
        if (e.mask[M_IMM])
            check_val("o_imm_ext", o_imm_ext, e.imm_ext);
        if (e.mask[M_DEST])
            check_val("o_dest_reg", 32'(o_dest_reg), 32'(e.dest_reg));
        if (e.mask[M_LINKV])
            check_val("o_link_value", o_link_value, e.link_value);
        if (e.mask[M_SIZE])
            check_val("o_mem_size", 32'(o_mem_size), 32'(e.mem_size));
        if (e.mask[M_UNS])
            check_val("o_mem_unsigned", 32'(o_mem_unsigned), 32'(e.mem_unsigned));
        if (e.mask[M_TARGET])
            check_val("o_branch_target", o_branch_target, e.target);
    endtask

    // One entry per falling edge, so the front entry left the stage at the last edge
    always @(posedge i_clk) begin
        if (exp_q.size() >= 2)
            compare_outputs(exp_q.pop_front());
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic drive_cycle(input logic valid, input word_t instr, input word_t pc,
                               input logic wb_en, input reg_addr_t wb_reg,
                               input word_t wb_data);
        exp_t  e;
        word_t rs_val;
        word_t rt_val;
        @(negedge i_clk);
        i_valid   = valid;
        i_instr   = instr;
        i_pc      = pc;
        i_wb_en   = wb_en;
        i_wb_reg  = wb_reg;
        i_wb_data = wb_data;
        rs_val = read_reg(instr[25:21], wb_en, wb_reg, wb_data);
        rt_val = read_reg(instr[20:16], wb_en, wb_reg, wb_data);
        e = valid ? predict(instr, pc, rs_val, rt_val) : '0;   // Bubble when idle
        exp_q.push_back(e);
        if (wb_en && wb_reg != 5'd0)
            mirror[wb_reg] = wb_data;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic write_back(input reg_addr_t reg_num, input word_t data);
        drive_cycle(1'b0, '0, '0, 1'b1, reg_num, data);
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        idle_cycle();                      // Lets the last instruction reach its compare
        $display("Test %s done, %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic reset_and_bubbles();
        check_val("o_valid", 32'(o_valid), 32'd0);
        check_val("o_reg_write", 32'(o_reg_write), 32'd0);
        check_val("o_mem_op", 32'(o_mem_op), 32'd0);
        check_val("o_branch_taken", 32'(o_branch_taken), 32'd0);
        repeat (3) idle_cycle();
        write_back(5'd0, next_rand());
        // r7 was written during reset and must still read zero
        drive_cycle(1'b1, rtype_word(5'd0, 5'd7, 5'd7, 5'd0, 6'h20), rand_pc(),
                    1'b0, '0, '0);
        // Same-cycle write to r0 must not be forwarded
        drive_cycle(1'b1, rtype_word(5'd0, 5'd0, 5'd9, 5'd0, 6'h21), rand_pc(),
                    1'b1, 5'd0, next_rand());
        end_test("reset_and_bubbles");
    endtask

    task automatic rtype_ops();
        word_t  r;
        word_t  w;
        funct_t fn;
        for (int i = 1; i < 32; i++)
            write_back(reg_addr_t'(i), next_rand());
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            w  = next_rand();
            fn = r[5:0];
            if (fn == FN_JR || fn == FN_JALR)
                fn = 6'h20;
            if (i % 8 == 0) begin
                w[9:5] = r[25:21];         // Write-back hits rs in the same cycle
                w[0]   = 1'b1;
            end
            drive_cycle(1'b1, rtype_word(r[25:21], r[20:16], r[15:11], r[10:6], fn),
                        rand_pc(), w[0], w[9:5], next_rand());
        end
        end_test("rtype");
    endtask

    task automatic imm_ops();
        word_t r;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            drive_cycle(1'b1, itype_word({3'b001, r[2:0]}, r[25:21], r[20:16], r[31:16]),
                        rand_pc(), 1'b0, '0, '0);
        end
        end_test("imm_arith");
    endtask

    task automatic mem_ops();
        word_t r;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            drive_cycle(1'b1, itype_word({2'b10, r[3], r[2:0]}, r[25:21], r[20:16], r[31:16]),
                        rand_pc(), 1'b0, '0, '0);
        end
        end_test("load_store");
    endtask

    task automatic jump_ops();
        word_t r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            drive_cycle(1'b1, jtype_word(OP_J, r[25:0]), rand_pc(), 1'b0, '0, '0);
            drive_cycle(1'b1, jtype_word(OP_JAL, r[31:6]), rand_pc(), 1'b0, '0, '0);
            drive_cycle(1'b1, rtype_word(r[25:21], 5'd0, 5'd0, 5'd0, FN_JR), rand_pc(),
                        1'b0, '0, '0);
            drive_cycle(1'b1, rtype_word(r[20:16], 5'd0, r[15:11], 5'd0, FN_JALR),
                        rand_pc(), 1'b0, '0, '0);
        end
        end_test("jumps");
    endtask

    task automatic branch_ops();
        word_t     r;
        reg_addr_t rt;
        opcode_t   op;
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            op = r[0] ? OP_BEQ : OP_BNE;
            rt = r[11:7];
            if (rt == 5'd0)
                rt = 5'd1;
            // Equal case copies the rs value into rt in the same cycle
            drive_cycle(1'b1, itype_word(op, r[6:2], rt, r[31:16]), rand_pc(),
                        r[1], rt, read_reg(r[6:2], 1'b0, '0, '0));
        end
        end_test("branches");
    endtask

    initial begin
        i_reset   = 1'b1;
        i_valid   = 1'b1;                  // Reset must override a valid load
        i_instr   = itype_word(6'b100011, 5'd1, 5'd2, 16'h0004);
        i_pc      = '0;
        i_wb_en   = 1'b1;                  // Write during reset is dropped
        i_wb_reg  = 5'd7;
        i_wb_data = next_rand();
        foreach (mirror[i])
            mirror[i] = '0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        i_valid = 1'b0;
        i_wb_en = 1'b0;

        reset_and_bubbles();
        rtype_ops();
        imm_ops();
        mem_ops();
        jump_ops();
        branch_ops();

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- mips_decode.f
rtl/mips_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/branch_resolver.sv
rtl/id_ex_register.sv
rtl/decode_stage.sv
bench/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_decode

verilator --binary --timing --assert --top-module tb_decode_stage \
    -f mips_decode.f -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
